// ==== design/fpAddSubPkg.sv ====
package fpAddSubPkg;

	localparam int expWidth = 5;      // Exponent field
	localparam int mantWidth = 10;    // Stored mantissa, hidden bit not counted
	localparam int dataWidth = 16;    // Sign, exponent, mantissa
	localparam int expBias = 15;
	localparam int expMax = 31;       // Infinity and NaN exponent
	localparam logic [dataWidth-1:0] qNaN = 16'h7E00; // Only NaN ever produced
	localparam int pipeLatency = 5;   // One cycle per registered stage

	typedef logic [dataWidth-1:0] fpWordT;
	typedef logic [expWidth-1:0] expT;
	typedef logic signed [expWidth+1:0] expWideT;  // Room for carry and large left shifts
	typedef logic [mantWidth+3:0] sigT;            // Hidden, mantissa, guard, round, sticky
	typedef logic [mantWidth+4:0] sumT;            // sigT plus carry out
	typedef logic [4:0] inExcT;  // nanA, nanB, inf minus inf, infA, infB
	typedef logic [4:0] flagT;   // Overflow, Underflow, DivideByZero, Invalid, Inexact

	typedef struct packed {
		logic valid;
		logic sign;      // Sign of larger operand
		logic effSub;    // Signs differ after subtract applied
		expT exp;        // Exponent of larger operand
		expT expDiff;
		sigT bigSig;
		sigT smallSig;
		inExcT inExc;
	} unpackStageT;

	typedef struct packed {
		logic valid;
		logic sign;
		logic effSub;
		expT exp;
		sigT bigSig;
		sigT smallSig;   // Aligned, sticky in bit 0
		inExcT inExc;
	} alignStageT;

	typedef struct packed {
		logic valid;
		logic sign;
		expT exp;
		sumT sum;
		inExcT inExc;
	} sumStageT;

	typedef struct packed {
		logic valid;
		logic sign;
		expWideT exp;
		sigT sig;        // Hidden bit at MSB unless zero
		inExcT inExc;
		logic zero;      // Exact cancellation or both operands zero
	} normStageT;

	typedef struct packed {
		logic valid;
		fpWordT z;       // Rounded or substituted result
		logic negE;      // Exponent fell below smallest normal
		logic r;         // Round bit
		logic s;         // Sticky bit
		inExcT inExc;
		logic eof;       // Exponent overflow
	} roundOutT;

endpackage

// ==== design/fpAddSubUnpack.sv ====
module fpAddSubUnpack (
	input  logic                     clk,
	input  logic                     arstN,
	input  logic                     inValid,
	input  fpAddSubPkg::fpWordT      a,
	input  fpAddSubPkg::fpWordT      b,
	input  logic                     subtract,
	output fpAddSubPkg::unpackStageT stage
);
	import fpAddSubPkg::*;

	logic signA, signB;
	expT expA, expB;
	logic zeroA, zeroB, infA, infB, nanA, nanB;
	logic [dataWidth-2:0] magA, magB;  // Exponent and mantissa, zero when subnormal
	sigT sigA, sigB;
	logic swap;
	unpackStageT nxt;

	assign signA = a[dataWidth-1];
	assign signB = b[dataWidth-1] ^ subtract;  // a - b is a + (-b)
	assign expA = a[dataWidth-2 -: expWidth];
	assign expB = b[dataWidth-2 -: expWidth];

	// Subnormals read as zero
	assign zeroA = (expA == '0);
	assign zeroB = (expB == '0);
	assign infA = (expA == expT'(expMax)) && (a[mantWidth-1:0] == '0);
	assign infB = (expB == expT'(expMax)) && (b[mantWidth-1:0] == '0);
	assign nanA = (expA == expT'(expMax)) && (a[mantWidth-1:0] != '0);
	assign nanB = (expB == expT'(expMax)) && (b[mantWidth-1:0] != '0);

	assign magA = zeroA ? '0 : a[dataWidth-2:0];
	assign magB = zeroB ? '0 : b[dataWidth-2:0];
	assign sigA = zeroA ? '0 : {1'b1, a[mantWidth-1:0], 3'b000};  // GRS start clear
	assign sigB = zeroB ? '0 : {1'b1, b[mantWidth-1:0], 3'b000};

	// Equal magnitudes keep a on top
	assign swap = (magB > magA);

	always_comb begin
		nxt.valid = inValid;
		nxt.effSub = signA ^ signB;
		nxt.inExc = {nanA, nanB, infA & infB & nxt.effSub, infA, infB};
		if (swap) begin
			nxt.sign = signB;
			nxt.exp = magB[dataWidth-2 -: expWidth];
			nxt.expDiff = magB[dataWidth-2 -: expWidth] - magA[dataWidth-2 -: expWidth];
			nxt.bigSig = sigB;
			nxt.smallSig = sigA;
		end else begin
			nxt.sign = signA;
			nxt.exp = magA[dataWidth-2 -: expWidth];
			nxt.expDiff = magA[dataWidth-2 -: expWidth] - magB[dataWidth-2 -: expWidth];
			nxt.bigSig = sigA;
			nxt.smallSig = sigB;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			stage <= '0;
		else
			stage <= nxt;
	end

endmodule

// ==== design/fpAddSubAlign.sv ====
module fpAddSubAlign (
	input  logic                     clk,
	input  logic                     arstN,
	input  fpAddSubPkg::unpackStageT stageIn,
	output fpAddSubPkg::alignStageT  stage
);
	import fpAddSubPkg::*;

	logic [3:0] shAmt;
	sigT shifted;
	sigT lostMask;   // Bits that fall off the bottom
	logic sticky;
	alignStageT nxt;

	// Past 14 places everything lands in sticky anyway
	assign shAmt = (stageIn.expDiff > 5'd14) ? 4'd14 : stageIn.expDiff[3:0];
	assign shifted = stageIn.smallSig >> shAmt;
	assign lostMask = ~({$bits(sigT){1'b1}} << shAmt);
	assign sticky = |(stageIn.smallSig & lostMask);

	always_comb begin
		nxt.valid = stageIn.valid;
		nxt.sign = stageIn.sign;
		nxt.effSub = stageIn.effSub;
		nxt.exp = stageIn.exp;
		nxt.bigSig = stageIn.bigSig;
		nxt.smallSig = {shifted[$bits(sigT)-1:1], shifted[0] | sticky};  // Fold lost bits
		nxt.inExc = stageIn.inExc;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			stage <= '0;
		else
			stage <= nxt;
	end

endmodule

// ==== design/fpAddSubExecute.sv ====
module fpAddSubExecute (
	input  logic                    clk,
	input  logic                    arstN,
	input  fpAddSubPkg::alignStageT stageIn,
	output fpAddSubPkg::sumStageT   stage
);
	import fpAddSubPkg::*;

	sumT bigExt, smallExt;
	sumStageT nxt;

	assign bigExt = sumT'(stageIn.bigSig);
	assign smallExt = sumT'(stageIn.smallSig);

	always_comb begin
		nxt.valid = stageIn.valid;
		nxt.sign = stageIn.sign;  // Big operand decides, difference never negative
		nxt.exp = stageIn.exp;
		nxt.inExc = stageIn.inExc;
		if (stageIn.effSub)
			nxt.sum = bigExt - smallExt;   // Sticky acts as borrow hint
		else
			nxt.sum = bigExt + smallExt;   // MSB is carry out
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			stage <= '0;
		else
			stage <= nxt;
	end

endmodule

// ==== design/fpAddSubNormalize.sv ====
module fpAddSubNormalize (
	input  logic                   clk,
	input  logic                   arstN,
	input  fpAddSubPkg::sumStageT  stageIn,
	output fpAddSubPkg::normStageT stage
);
	import fpAddSubPkg::*;

	logic [3:0] lzCount;  // 14 means no bit set
	sigT low;             // Sum without carry bit
	normStageT nxt;

	assign low = stageIn.sum[$bits(sigT)-1:0];

	// Highest set bit wins, loop runs upward
	always_comb begin
		lzCount = 4'd14;
		for (int i = 0; i < $bits(sigT); i++) begin
			if (low[i])
				lzCount = 4'($bits(sigT) - 1 - i);
		end
	end

	always_comb begin
		nxt.valid = stageIn.valid;
		nxt.inExc = stageIn.inExc;
		nxt.sign = stageIn.sign;
		nxt.zero = 1'b0;
		if (stageIn.sum[$bits(sumT)-1]) begin
			// Carry out, one place right, keep sticky
			nxt.sig = {stageIn.sum[$bits(sumT)-1:2], |stageIn.sum[1:0]};
			nxt.exp = expWideT'(stageIn.exp) + expWideT'(1);
		end else if (lzCount == 4'd14) begin
			// Nothing left, round to nearest gives +0
			nxt.sign = 1'b0;
			nxt.sig = '0;
			nxt.exp = '0;
			nxt.zero = 1'b1;
		end else begin
			nxt.sig = low << lzCount;
			nxt.exp = expWideT'(stageIn.exp) - expWideT'(lzCount);  // May go negative
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			stage <= '0;
		else
			stage <= nxt;
	end

endmodule

// ==== design/fpAddSubRound.sv ====
module fpAddSubRound (
	input  logic                   clk,
	input  logic                   arstN,
	input  fpAddSubPkg::normStageT stageIn,
	output fpAddSubPkg::roundOutT  stage
);
	import fpAddSubPkg::*;

	logic guard, roundBit, stickyBit, roundUp;
	logic [mantWidth+1:0] rounded;  // Carry, hidden, mantissa
	logic [mantWidth-1:0] mant;
	expWideT expR;
	roundOutT nxt;

	assign guard = stageIn.sig[2];
	assign roundBit = stageIn.sig[1];
	assign stickyBit = stageIn.sig[0];
	assign roundUp = guard & (roundBit | stickyBit | stageIn.sig[3]);  // Ties to even

	assign rounded = {1'b0, stageIn.sig[$bits(sigT)-1:3]} + (mantWidth+2)'(roundUp);
	// Mantissa carry, value becomes 1.0 at next exponent
	assign mant = rounded[mantWidth+1] ? rounded[mantWidth:1] : rounded[mantWidth-1:0];
	assign expR = stageIn.exp + expWideT'(rounded[mantWidth+1]);

	always_comb begin
		nxt.valid = stageIn.valid;
		nxt.inExc = stageIn.inExc;
		nxt.r = guard;
		nxt.s = roundBit | stickyBit;
		nxt.eof = 1'b0;
		nxt.negE = 1'b0;
		nxt.z = {stageIn.sign, expT'(expR), mant};
		if (|stageIn.inExc[4:2]) begin
			nxt.z = qNaN;                // NaN in, or inf minus inf
			nxt.r = 1'b0;
			nxt.s = 1'b0;
		end else if (|stageIn.inExc[1:0]) begin
			// Infinite operand is always the big one
			nxt.z = {stageIn.sign, expT'(expMax), {mantWidth{1'b0}}};
			nxt.r = 1'b0;
			nxt.s = 1'b0;
		end else if (stageIn.zero) begin
			nxt.z = '0;
		end else if (expR >= expMax) begin
			nxt.eof = 1'b1;
			nxt.z = {stageIn.sign, expT'(expMax), {mantWidth{1'b0}}};
		end else if (expR < 1) begin
			// Flush to signed zero, whole value lost
			nxt.negE = 1'b1;
			nxt.r = 1'b1;
			nxt.z = {stageIn.sign, {(dataWidth-1){1'b0}}};
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			stage <= '0;
		else
			stage <= nxt;
	end

endmodule

// ==== design/fpAddSubException.sv ====
module fpAddSubException (
	input  fpAddSubPkg::roundOutT stageIn,
	output fpAddSubPkg::fpWordT   result,
	output fpAddSubPkg::flagT     flags
);
	import fpAddSubPkg::*;

	logic overflow;
	logic underflow;
	logic divideByZero;  // Never raised by add or subtract
	logic invalid;
	logic inexact;

	// Too large, or an infinite operand
	assign overflow = stageIn.eof | stageIn.inExc[1] | stageIn.inExc[0];

	// Too small and something was dropped
	assign underflow = stageIn.negE & (stageIn.r | stageIn.s);

	assign divideByZero = 1'b0;

	assign invalid = |stageIn.inExc[4:2];  // NaN operand or inf minus inf

	// Rounding, overflow or underflow lost precision
	assign inexact = stageIn.r | stageIn.s | overflow | underflow;

	assign result = stageIn.z;
	assign flags = {overflow, underflow, divideByZero, invalid, inexact};

endmodule

// ==== design/fpAddSub.sv ====
module fpAddSub (
	input  logic                clk,
	input  logic                arstN,
	input  logic                inValid,
	input  fpAddSubPkg::fpWordT a,
	input  fpAddSubPkg::fpWordT b,
	input  logic                subtract,   // 1 for a - b
	output logic                outValid,
	output fpAddSubPkg::fpWordT result,
	output fpAddSubPkg::flagT   flags
);
	import fpAddSubPkg::*;

	unpackStageT unpackStage;
	alignStageT alignStage;
	sumStageT sumStage;
	normStageT normStage;
	roundOutT roundOut;

	// Cycle 1, classify and swap
	fpAddSubUnpack uUnpack (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.a        (a),
		.b        (b),
		.subtract (subtract),
		.stage    (unpackStage)
	);

	// Cycle 2
	fpAddSubAlign uAlign (
		.clk     (clk),
		.arstN   (arstN),
		.stageIn (unpackStage),
		.stage   (alignStage)
	);

	// Cycle 3
	fpAddSubExecute uExecute (
		.clk     (clk),
		.arstN   (arstN),
		.stageIn (alignStage),
		.stage   (sumStage)
	);

	// Cycle 4
	fpAddSubNormalize uNormalize (
		.clk     (clk),
		.arstN   (arstN),
		.stageIn (sumStage),
		.stage   (normStage)
	);

	// Cycle 5, last register
	fpAddSubRound uRound (
		.clk     (clk),
		.arstN   (arstN),
		.stageIn (normStage),
		.stage   (roundOut)
	);

	fpAddSubException uException (
		.stageIn (roundOut),
		.result  (result),
		.flags   (flags)
	);

	assign outValid = roundOut.valid;

endmodule

// ==== sim/tbClockGen.sv ====
module tbClockGen (
	output logic clk
);

	// Free running, period of 4
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

endmodule

// ==== sim/tbFpAddSub.sv ====
module tbFpAddSub;
	import fpAddSubPkg::*;

	logic clk;
	logic arstN;
	logic inValid;
	fpWordT a, b;
	logic subtract;
	logic outValid;
	fpWordT result;
	flagT flags;

	integer seed;
	int errorCount, checkCount, cycleCount;
	bit timedOut;

	// Scoreboard holds one entry per accepted input
	fpWordT expResultQ[$];
	flagT expFlagsQ[$];
	string nameQ[$];
	int dueQ[$];           // Cycle at which the result must show up

	fpWordT popRes;
	flagT popFlg;
	string popName;
	int popDue;

	tbClockGen clockGen (.clk(clk));

	fpAddSub u_dut (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.a        (a),
		.b        (b),
		.subtract (subtract),
		.outValid (outValid),
		.result   (result),
		.flags    (flags)
	);

	always @(posedge clk) cycleCount <= cycleCount + 1;

	// Exact value of a half word with subnormals read as zero
	function automatic real halfToReal(input fpWordT w);
		int e;
		real v;
		e = w[14:10];
		if (e == 0)
			return 0.0;
		v = 1.0 + w[9:0] / 1024.0;
		e = e - expBias;
		while (e > 0) begin
			v = v * 2.0;
			e--;
		end
		while (e < 0) begin
			v = v / 2.0;
			e++;
		end
		return w[15] ? -v : v;
	endfunction

	// Exact sum in real, rounded back to half with ties to even
	task automatic modelAddSub(input fpWordT x, input fpWordT y, input logic sub,
			output fpWordT res, output flagT flg);
		logic sx, sy, sign;
		logic nanX, nanY, infX, infY;
		logic ovf, unf, inexact;
		real sum, mag, frac, rem;
		int e, intPart, biased;
		sx = x[15];
		sy = y[15] ^ sub;                 // a - b as a + (-b)
		nanX = (x[14:10] == 5'h1F) && (x[9:0] != 0);
		nanY = (y[14:10] == 5'h1F) && (y[9:0] != 0);
		infX = (x[14:10] == 5'h1F) && (x[9:0] == 0);
		infY = (y[14:10] == 5'h1F) && (y[9:0] == 0);
		ovf = infX | infY;                // Infinite operand counts as overflow
		unf = 1'b0;
		if (nanX || nanY || (infX && infY && sx != sy)) begin
			res = 16'h7E00;
			flg = {ovf, 1'b0, 1'b0, 1'b1, ovf};
		end else if (ovf) begin
			res = {infX ? sx : sy, 5'h1F, 10'h000};
			flg = 5'b10001;
		end else begin
			sum = sub ? halfToReal(x) - halfToReal(y) : halfToReal(x) + halfToReal(y);
			if (sum == 0.0) begin
				res = 16'h0000;               // Cancellation always +0
				flg = 5'b00000;
			end else begin
				sign = (sum < 0.0);
				mag = sign ? -sum : sum;
				e = 0;
				while (mag >= 2.0) begin
					mag = mag / 2.0;
					e++;
				end
				while (mag < 1.0) begin
					mag = mag * 2.0;
					e--;
				end
				frac = mag * 1024.0;          // 11 significant bits above the point
				intPart = $rtoi(frac);
				rem = frac - intPart;
				inexact = (rem != 0.0);
				if (rem > 0.5 || (rem == 0.5 && intPart[0]))
					intPart++;
				if (intPart == 2048) begin
					intPart = 1024;
					e++;
				end
				biased = e + expBias;
				if (biased >= expMax) begin
					ovf = 1'b1;
					res = {sign, 5'h1F, 10'h000};
				end else if (biased < 1) begin
					unf = 1'b1;                 // Below smallest normal so flush
					res = {sign, 15'h0000};
				end else begin
					res = {sign, biased[4:0], intPart[9:0]};
				end
				flg = {ovf, unf, 1'b0, 1'b0, inexact | ovf | unf};
			end
		end
	endtask

	// About one in eight is zero, infinity, NaN or subnormal
	function automatic fpWordT randomOperand(input int baseExp);
		int r, gap, e;
		logic sign;
		logic [9:0] mant;
		r = $random(seed);
		sign = r[15];
		mant = r[9:0];
		if (r[18:16] == 3'd0) begin
			case (r[21:20])
				2'd0: return {sign, 15'h0000};
				2'd1: return {sign, 5'h1F, 10'h000};
				2'd2: return {sign, 5'h1F, mant | 10'h001};
				default: return {sign, 5'h00, mant};
			endcase
		end
		gap = r[25:23];
		if (r[28:26] == 3'd0)
			gap = gap * 3;                  // Now and then a wide gap for sticky
		e = baseExp + gap - 2;
		if (e < 1)
			e = 1;
		if (e > 30)
			e = 30;
		return {sign, e[4:0], mant};
	endfunction

	task automatic applyOp(input string name, input fpWordT x, input fpWordT y,
			input logic sub);
		fpWordT expRes;
		flagT expFlg;
		@(negedge clk);
		a = x;
		b = y;
		subtract = sub;
		inValid = 1'b1;
		modelAddSub(x, y, sub, expRes, expFlg);
		expResultQ.push_back(expRes);
		expFlagsQ.push_back(expFlg);
		nameQ.push_back(name);
		dueQ.push_back(cycleCount + pipeLatency);  // Five cycles after the drive cycle
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(negedge clk);
			inValid = 1'b0;
		end
	endtask

	task automatic popEntry();
		popRes = expResultQ.pop_front();
		popFlg = expFlagsQ.pop_front();
		popName = nameQ.pop_front();
		popDue = dueQ.pop_front();
	endtask

	// Outputs sampled mid cycle away from the rising edge
	always @(negedge clk) begin
		if (!arstN) begin
			assert (!outValid) else begin
				errorCount++;
				$display("outValid was high while reset was asserted");
			end
		end else if (outValid) begin
			assert (expResultQ.size() != 0) else begin
				errorCount++;
				$display("outValid was high with no input pending");
			end
			if (expResultQ.size() != 0) begin
				popEntry();
				checkCount++;
				assert (result == popRes) else begin
					errorCount++;
					$display("ERROR %s: result expected %h actual %h", popName, popRes, result);
				end
				assert (flags == popFlg) else begin
					errorCount++;
					$display("ERROR %s: flags expected %b actual %b", popName, popFlg, flags);
				end
				assert (cycleCount == popDue) else begin
					errorCount++;
					$display("ERROR %s: latency expected %0d actual %0d", popName, pipeLatency,
						cycleCount - popDue + pipeLatency);
				end
			end
		end else if (dueQ.size() != 0) begin
			assert (cycleCount < dueQ[0]) else begin
				errorCount++;
				$display("No result came out for %s at the expected cycle", nameQ[0]);
				popEntry();                   // Drop it so it is not reported again
			end
		end
	end

	initial begin
		int r, baseExp, waitCycles;
		fpWordT x, y;
		seed = 80;
		arstN = 1'b0;
		inValid = 1'b0;
		a = '0;
		b = '0;
		subtract = 1'b0;
		cycleCount = 0;
		errorCount = 0;
		checkCount = 0;
		timedOut = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		idleCycles(4);                    // outValid must stay low here

		// Corner cases back to back
		applyOp("tieEven", 16'h3C00, 16'h1000, 1'b0);
		applyOp("tieOdd", 16'h3C01, 16'h1000, 1'b0);
		applyOp("overflow", 16'h7BFF, 16'h7BFF, 1'b0);
		applyOp("overflowTie", 16'h7BFF, 16'h4C00, 1'b0);
		applyOp("infOperand", 16'hFC00, 16'h3C00, 1'b0);
		applyOp("underflow", 16'h0600, 16'h0400, 1'b1);
		applyOp("underflowNeg", 16'h0400, 16'h0600, 1'b1);
		applyOp("cancel", 16'h3C00, 16'h3C00, 1'b1);
		applyOp("nanOperand", 16'h3C00, 16'h7E01, 1'b0);
		applyOp("infMinusInf", 16'h7C00, 16'h7C00, 1'b1);
		applyOp("zeroZero", 16'h8000, 16'h8000, 1'b0);
		idleCycles(3);

		for (int i = 0; i < 400; i++) begin
			r = $random(seed);
			baseExp = 1 + (r[7:0] % 30);
			x = randomOperand(baseExp);
			y = randomOperand(baseExp);
			if (r[11:8] == 4'd0)
				y = x;                        // Force cancellation or doubling
			applyOp($sformatf("random%0d", i), x, y, r[12]);
			if (r[16:13] == 4'd0)
				idleCycles(1);                // Occasional bubble
		end
		idleCycles(1);

		waitCycles = 0;
		while (expResultQ.size() != 0 && !timedOut) begin
			@(negedge clk);
			waitCycles++;
			if (waitCycles > 20 * pipeLatency)
				timedOut = 1'b1;
		end
		if (timedOut) begin
			errorCount++;
			$display("Timeout: pipeline did not drain, %0d results pending", expResultQ.size());
		end

		$display("Checked %0d results, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== list.f ====
design/fpAddSubPkg.sv
design/fpAddSubUnpack.sv
design/fpAddSubAlign.sv
design/fpAddSubExecute.sv
design/fpAddSubNormalize.sv
design/fpAddSubRound.sv
design/fpAddSubException.sv
design/fpAddSub.sv
sim/tbClockGen.sv
sim/tbFpAddSub.sv
